// File: rv_wb.f
+incdir+design
design/rv_wb_pkg.sv
design/csr_if.sv
design/csr_file.sv
design/wb_stage.sv
design/reg_file.sv
design/wb_top.sv
sim/wb_chk.sv
sim/wb_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_wb.f --top-module wb_tb \
	-Mdir obj_dir -o wb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/wb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
exit 1

// File: sim/wb_tb.sv
`timescale 1ns/1ps
`include "rv_wb_cfg.svh"

module wb_tb import rv_wb_pkg::*; ();
	localparam int N_CYCLES = 3000;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_STALL = 1;		// Every loop pass is one clock.
	localparam int TIMEOUT = 2 * N_CYCLES * MAX_STALL + RESET_CYCLES;

	logic clk = 1'b0, reset, valid_in, ready_out, ready_in, valid_out, flush_in, flush_out;
	word_t pc_mem, ir_mem, rd_data_mem, csr_wdata_mem, pc_wb, ir_wb, trap_addr, trap_raddr;
	word_t rs1_data, rs2_data;
	logic rd_wena_mem, csr_rena_mem, csr_wena_mem, trap_ret_mem, exc_pend_mem;
	reg_addr_t rd_addr_mem, rs1_addr, rs2_addr;
	wb_src_e wb_src_mem;
	csr_op_e csr_op_mem;
	csr_addr_t csr_addr_mem;
	fflags_t fflags_mem;
	cause_t exc_cause_mem;
	logic [`NUM_IRQ_EXT-1:0] irq_ext;
	logic irq_int_controller, irq_timer, irq_software, m_ena, f_ena;
	frm_t fpu_rm;
	logic int_taken, exc_taken, trap_taken;

	// Reference state.
	word_t m_regs [64];
	logic m_mie, m_mpie, m_ena_q, m_fena, m_valid, have_pc;
	logic [1:0] m_fs;
	word_t m_ie, m_ip, m_tvec, m_epc, m_pc_wb, m_ir_wb;
	cause_t m_cause;
	fflags_t m_fflags;
	frm_t m_frm;
	logic [31:0] seed = 32'd83021;
	int cycles = 0;
	csr_addr_t csr_list [10] = '{`CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MIP, `CSR_MTVEC,
		`CSR_MEPC, `CSR_MCAUSE, `CSR_FFLAGS, `CSR_FRM, `CSR_FCSR};

	wb_top u_dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles without finishing the test", cycles);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return {seed[15:0], seed[31:16]};
	endfunction

	function automatic word_t csr_value(csr_addr_t a);
		word_t v = '0;
		case (a)
			`CSR_MSTATUS: v = {17'b0, m_fs, 2'b11, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
			`CSR_MISA: v = {2'b01, 17'b0, m_ena_q, 3'b0, 1'b1, 2'b0, m_fena, 5'b0};
			`CSR_MIE: v = m_ie;
			`CSR_MIP: v = m_ip;
			`CSR_MTVEC: v = m_tvec;
			`CSR_MEPC: v = m_epc;
			`CSR_MCAUSE: v = m_cause;
			`CSR_FFLAGS: v[4:0] = m_fflags;
			`CSR_FRM: v[2:0] = m_frm;
			`CSR_FCSR: v[7:0] = {m_frm, m_fflags};
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic fail_now(string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_word(string what, word_t got, word_t exp);
		if (got !== exp)
			fail_now($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_cause(string what, cause_t got, cause_t exp);
		if (got !== exp)
			fail_now($sformatf("%s cause is %h, expected %h", what, got, exp));
	endtask

	task automatic check_frm(string what, frm_t got, frm_t exp);
		if (got !== exp)
			fail_now($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		if (got !== exp)
			fail_now($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// Checks the DUT against the model before the edge and then advances the model.
	task automatic step_model();
		logic acc, exc, intr, trap, retire, o_mie, o_mpie;
		word_t lines, pend, old_v, new_v, mask;
		cause_t icause;
		acc = valid_in && ready_in;
		lines = {irq_ext, 4'b0, irq_int_controller, 3'b0, irq_timer, 3'b0, irq_software, 3'b0};
		mask = 32'hFFFF_0888;
		pend = m_ip & m_ie;
		icause = 32'h8000_0000;
		for (int i = 0; i < 32; i++)
			if (pend[i])
				icause = 32'h8000_0000 | i;
		exc = acc && exc_pend_mem;
		intr = acc && !exc_pend_mem && m_mie && (pend != '0);
		trap = exc || intr;
		retire = acc && !trap;
		check_bit("ready_out", ready_out, ready_in);
		check_bit("flush_out", flush_out, flush_in);
		check_bit("valid_out", valid_out, m_valid);
		check_bit("exc_taken", exc_taken, exc);
		check_bit("int_taken", int_taken, intr);
		check_bit("trap_taken", trap_taken, trap);
		check_bit("m_ena", m_ena, m_ena_q);
		check_bit("f_ena", f_ena, m_fena);
		check_frm("fpu_rm", fpu_rm, m_frm);
		check_word("trap_raddr", trap_raddr, m_epc);
		check_cause("mcause", u_dut.u_csr.mcause, m_cause);
		check_word("rs1_data", rs1_data, m_regs[rs1_addr]);
		check_word("rs2_data", rs2_data, m_regs[rs2_addr]);
		if (trap)
			check_word("trap_addr", trap_addr, {m_tvec[31:2], 2'b00});
		if (have_pc) begin
			check_word("pc_wb", pc_wb, m_pc_wb);
			check_word("ir_wb", ir_wb, m_ir_wb);
		end
		old_v = csr_value(csr_addr_mem);
		new_v = (csr_op_mem == CSR_RW) ? csr_wdata_mem :
			(csr_op_mem == CSR_RS) ? (old_v | csr_wdata_mem) :
			(csr_op_mem == CSR_RC) ? (old_v & ~csr_wdata_mem) : old_v;
		o_mie = m_mie;
		o_mpie = m_mpie;
		if (retire && rd_wena_mem && rd_addr_mem != '0)
			m_regs[rd_addr_mem] = (wb_src_mem == SEL_CSR) ?
				(csr_rena_mem ? old_v : '0) : rd_data_mem;
		m_ip = lines;
		if (retire)
			m_fflags = m_fflags | fflags_mem;
		if (retire && csr_wena_mem && csr_op_mem != CSR_NONE) begin
			case (csr_addr_mem)
				`CSR_MSTATUS: {m_fs, m_mpie, m_mie} = {new_v[14:13], new_v[7], new_v[3]};
				`CSR_MISA: {m_ena_q, m_fena} = {new_v[12], new_v[5]};
				`CSR_MIE: m_ie = new_v & mask;
				`CSR_MTVEC: m_tvec = new_v;
				`CSR_MEPC: m_epc = new_v;
				`CSR_MCAUSE: m_cause = new_v;
				`CSR_FFLAGS: m_fflags = new_v[4:0] | fflags_mem;
				`CSR_FRM: m_frm = new_v[2:0];
				`CSR_FCSR: {m_frm, m_fflags} = {new_v[7:5], new_v[4:0] | fflags_mem};
				default: ;
			endcase
		end
		if (retire && rd_wena_mem && rd_addr_mem[5])
			m_fs = 2'b11;		// FP register write marks the FP state dirty.
		if (retire && trap_ret_mem) begin
			m_mie = o_mpie;
			m_mpie = 1'b1;
		end
		if (trap) begin
			m_epc = pc_mem;
			m_cause = exc ? exc_cause_mem : icause;
			m_mpie = o_mie;
			m_mie = 1'b0;
		end
		if (acc) begin
			m_pc_wb = pc_mem;
			m_ir_wb = ir_mem;
			have_pc = 1'b1;
		end
		m_valid = acc ? 1'b1 : (ready_in ? 1'b0 : m_valid);
	endtask

	task automatic drive_random();
		logic [31:0] r, q, d;
		r = next_rand();
		q = next_rand();
		d = next_rand();
		valid_in <= r[0];
		ready_in <= r[1] | r[2];
		rd_wena_mem <= r[3];
		rd_addr_mem <= r[9:4];
		wb_src_mem <= wb_src_e'(r[11:10]);
		csr_op_mem <= csr_op_e'(r[13:12]);
		csr_rena_mem <= r[14];
		csr_wena_mem <= r[15];
		fflags_mem <= r[20:16];
		trap_ret_mem <= (r[23:21] == 3'd0);
		exc_pend_mem <= (r[26:24] == 3'd0);
		flush_in <= r[27];
		rs1_addr <= q[5:0];
		rs2_addr <= q[11:6];
		csr_addr_mem <= csr_list[q[15:12] % 10];
		exc_cause_mem <= {28'b0, q[19:16]};
		irq_ext <= (q[22:20] == 3'd0) ? d[31:16] : '0;
		irq_int_controller <= (q[25:23] == 3'd0);
		irq_timer <= (q[28:26] == 3'd0);
		irq_software <= (q[31:29] == 3'd0);
		pc_mem <= {d[29:0], 2'b00};
		ir_mem <= ~d;
		rd_data_mem <= r ^ q;
		csr_wdata_mem <= d;
	endtask

	initial begin
		{reset, valid_in, ready_in, flush_in, rd_wena_mem, csr_rena_mem, csr_wena_mem} = 7'b1000000;
		{trap_ret_mem, exc_pend_mem, irq_int_controller, irq_timer, irq_software} = '0;
		{pc_mem, ir_mem, rd_data_mem, csr_wdata_mem, exc_cause_mem} = '0;
		{rd_addr_mem, rs1_addr, rs2_addr, csr_addr_mem, fflags_mem, irq_ext} = '0;
		wb_src_mem = SEL_ALU;
		csr_op_mem = CSR_NONE;
		for (int i = 0; i < 64; i++)
			m_regs[i] = '0;
		{m_mie, m_mpie, m_fs, m_valid, have_pc, m_ena_q, m_fena} = 8'b00000011;
		{m_ie, m_ip, m_epc, m_cause, m_fflags, m_frm} = '0;
		m_tvec = `MTVEC_RESET;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		for (int n = 0; n < N_CYCLES; n++) begin
			@(posedge clk);
			step_model();
			drive_random();
		end
		$display("Test OK");
		$finish;
	end

endmodule

// File: sim/wb_chk.sv
`timescale 1ns/1ps

module wb_chk (
	input	logic			clk,
	input	logic			reset,
	input	logic			valid_in,
	input	logic			ready_out,
	input	logic			ready_in,
	input	logic			valid_out,
	input	logic	[31:0]	pc_wb,
	input	logic	[31:0]	ir_wb,
	input	logic			rf_wena,
	input	logic			exc_taken,
	input	logic			int_taken,
	input	logic			trap_taken
);
	// The WB outputs hold while downstream stalls.
	a_hold: assert property (@(posedge clk) disable iff (reset)
		(valid_out && !ready_in) |=> ($stable(pc_wb) && $stable(ir_wb)))
		else $error("pc_wb or ir_wb changed under back-pressure");

	a_wena: assert property (@(posedge clk) disable iff (reset)
		rf_wena |-> (valid_in && ready_out))
		else $error("register write without a handshake");

	a_trap: assert property (@(posedge clk) disable iff (reset)
		trap_taken == (exc_taken || int_taken))
		else $error("trap_taken does not match exc_taken or int_taken");

	a_reset: assert property (@(posedge clk) reset |-> !valid_out)
		else $error("valid_out high during reset");

endmodule

bind wb_stage wb_chk u_chk (
	.clk, .reset, .valid_in, .ready_out, .ready_in, .valid_out, .pc_wb, .ir_wb, .rf_wena,
	.exc_taken(csr.exc_taken), .int_taken(csr.int_taken), .trap_taken(csr.trap_taken)
);

// File: design/wb_top.sv
`timescale 1ns/1ps
`include "rv_wb_cfg.svh"

module wb_top import rv_wb_pkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	logic						valid_in,
	output	logic						ready_out,
	input	logic						ready_in,
	output	logic						valid_out,
	input	logic						flush_in,
	output	logic						flush_out,
	input	word_t						pc_mem,
	input	word_t						ir_mem,
	input	logic						rd_wena_mem,
	input	reg_addr_t					rd_addr_mem,
	input	word_t						rd_data_mem,
	input	wb_src_e					wb_src_mem,
	input	csr_op_e					csr_op_mem,
	input	csr_addr_t					csr_addr_mem,
	input	logic						csr_rena_mem,
	input	logic						csr_wena_mem,
	input	word_t						csr_wdata_mem,
	input	fflags_t					fflags_mem,
	input	logic						trap_ret_mem,
	input	logic						exc_pend_mem,
	input	cause_t						exc_cause_mem,
	output	word_t						pc_wb,
	output	word_t						ir_wb,
	input	logic	[`NUM_IRQ_EXT-1:0]	irq_ext,
	input	logic						irq_int_controller,
	input	logic						irq_timer,
	input	logic						irq_software,
	output	logic						m_ena,
	output	logic						f_ena,
	output	frm_t						fpu_rm,
	output	logic						int_taken,
	output	logic						exc_taken,
	output	logic						trap_taken,
	output	word_t						trap_addr,
	output	word_t						trap_raddr,
	input	reg_addr_t					rs1_addr,
	output	word_t						rs1_data,
	input	reg_addr_t					rs2_addr,
	output	word_t						rs2_data
);
	logic		rf_wena;
	reg_addr_t	rf_waddr;
	word_t		rf_wdata;

	csr_if u_csr_if ();

	assign int_taken = u_csr_if.int_taken;
	assign exc_taken = u_csr_if.exc_taken;
	assign trap_taken = u_csr_if.trap_taken;
	assign trap_addr = u_csr_if.trap_addr;
	assign trap_raddr = u_csr_if.trap_raddr;

	wb_stage u_stage (
		.clk, .reset,
		.valid_in, .ready_out, .ready_in, .valid_out, .flush_in, .flush_out,
		.pc_mem, .ir_mem, .rd_wena_mem, .rd_addr_mem, .rd_data_mem, .wb_src_mem,
		.csr_op_mem, .csr_addr_mem, .csr_rena_mem, .csr_wena_mem, .csr_wdata_mem,
		.fflags_mem, .trap_ret_mem, .exc_pend_mem, .exc_cause_mem,
		.pc_wb, .ir_wb,
		.csr(u_csr_if.stage),
		.rf_wena, .rf_waddr, .rf_wdata
	);

	csr_file u_csr (
		.clk, .reset,
		.csr(u_csr_if.csr),
		.irq_ext, .irq_int_controller, .irq_timer, .irq_software,
		.m_ena, .f_ena, .fpu_rm
	);

	reg_file #(.DEPTH(`NUM_REGS)) u_regs (
		.clk, .reset,
		.wena(rf_wena), .waddr(rf_waddr), .wdata(rf_wdata),
		.raddr_a(rs1_addr), .rdata_a(rs1_data),
		.raddr_b(rs2_addr), .rdata_b(rs2_data)
	);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "rv_wb_cfg.svh"

module reg_file import rv_wb_pkg::*; #(
	parameter int DEPTH = `NUM_REGS
) (
	input	logic		clk,
	input	logic		reset,
	input	logic		wena,
	input	reg_addr_t	waddr,
	input	word_t		wdata,
	input	reg_addr_t	raddr_a,
	output	word_t		rdata_a,
	input	reg_addr_t	raddr_b,
	output	word_t		rdata_b
);
	// Entries from 32 up hold the floating-point registers.
	word_t regs [DEPTH];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				regs[i] <= '0;
		end else if (wena && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired to zero.
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import rv_wb_pkg::*; (
	input	logic		clk,
	input	logic		reset,

	input	logic		valid_in,
	output	logic		ready_out,
	input	logic		ready_in,
	output	logic		valid_out,
	input	logic		flush_in,
	output	logic		flush_out,

	input	word_t		pc_mem,
	input	word_t		ir_mem,
	input	logic		rd_wena_mem,
	input	reg_addr_t	rd_addr_mem,
	input	word_t		rd_data_mem,
	input	wb_src_e	wb_src_mem,
	input	csr_op_e	csr_op_mem,
	input	csr_addr_t	csr_addr_mem,
	input	logic		csr_rena_mem,
	input	logic		csr_wena_mem,
	input	word_t		csr_wdata_mem,
	input	fflags_t	fflags_mem,
	input	logic		trap_ret_mem,
	input	logic		exc_pend_mem,
	input	cause_t		exc_cause_mem,

	output	word_t		pc_wb,
	output	word_t		ir_wb,

	csr_if.stage		csr,

	output	logic		rf_wena,
	output	reg_addr_t	rf_waddr,
	output	word_t		rf_wdata
);
	logic accept;

	assign ready_out = ready_in;
	assign flush_out = flush_in;
	assign accept = valid_in && ready_out;

	assign csr.commit = accept;
	assign csr.op = csr_op_mem;
	assign csr.addr = csr_addr_mem;
	assign csr.wdata = csr_wdata_mem;
	assign csr.rena = csr_rena_mem;
	assign csr.wena = csr_wena_mem;
	assign csr.fflags = fflags_mem;
	assign csr.exc_pend = exc_pend_mem;
	assign csr.exc_cause = exc_cause_mem;
	assign csr.trap_ret = trap_ret_mem;
	assign csr.pc = pc_mem;
	assign csr.fpu_dirty = rf_wena && rd_addr_mem[5];

	// A trapping instruction leaves the register file untouched.
	assign rf_wena = accept && rd_wena_mem && !csr.trap_taken;
	assign rf_waddr = rd_addr_mem;
	assign rf_wdata = (wb_src_mem == SEL_CSR) ? csr.rdata : rd_data_mem;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			valid_out <= 1'b0;
		else if (accept)
			valid_out <= 1'b1;
		else if (ready_in)
			valid_out <= 1'b0;		// Downstream took the item.
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_wb <= pc_mem;
			ir_wb <= ir_mem;
		end
	end

endmodule

// File: design/csr_file.sv
`timescale 1ns/1ps
`include "rv_wb_cfg.svh"

module csr_file import rv_wb_pkg::*; (
	input	logic						clk,
	input	logic						reset,
	csr_if.csr							csr,
	input	logic	[`NUM_IRQ_EXT-1:0]	irq_ext,
	input	logic						irq_int_controller,
	input	logic						irq_timer,
	input	logic						irq_software,
	output	logic						m_ena,
	output	logic						f_ena,
	output	frm_t						fpu_rm
);
	localparam int IRQ_LO = 16;

	logic		mstatus_mie;
	logic		mstatus_mpie;
	logic [1:0]	mstatus_fs;
	word_t		mie;
	word_t		mip;
	word_t		mtvec;
	word_t		mepc;
	cause_t		mcause;
	fflags_t	fflags;
	frm_t		frm;

	word_t		irq_lines;
	word_t		mie_mask;
	word_t		int_pend;
	cause_t		int_cause;
	word_t		old_val;
	word_t		new_val;
	logic		retire;
	logic		csr_write;

	// Interrupt lines and the writable mie bits share one layout.
	always_comb begin
		irq_lines = '0;
		irq_lines[IRQ_LO +: `NUM_IRQ_EXT] = irq_ext;
		irq_lines[11] = irq_int_controller;
		irq_lines[7] = irq_timer;
		irq_lines[3] = irq_software;
		mie_mask = '0;
		mie_mask[IRQ_LO +: `NUM_IRQ_EXT] = '1;
		mie_mask[11] = 1'b1;
		mie_mask[7] = 1'b1;
		mie_mask[3] = 1'b1;
	end

	assign int_pend = mip & mie;

	// The highest pending code wins.
	always_comb begin
		int_cause = '0;
		for (int i = 0; i < `XLEN; i++) begin
			if (int_pend[i])
				int_cause = cause_t'(i);
		end
		int_cause[`XLEN-1] = 1'b1;
	end

	assign csr.exc_taken = csr.commit && csr.exc_pend;
	assign csr.int_taken = csr.commit && !csr.exc_pend && mstatus_mie && (|int_pend);
	assign csr.trap_taken = csr.exc_taken || csr.int_taken;
	assign csr.trap_addr = {mtvec[`XLEN-1:2], 2'b00};
	assign csr.trap_raddr = mepc;

	assign retire = csr.commit && !csr.trap_taken;
	assign csr_write = retire && csr.wena && (csr.op != CSR_NONE);

	always_comb begin
		old_val = '0;
		case (csr.addr)
			`CSR_MSTATUS: begin
				old_val[14:13] = mstatus_fs;
				old_val[12:11] = 2'b11;		// MPP is always machine mode.
				old_val[7] = mstatus_mpie;
				old_val[3] = mstatus_mie;
			end
			`CSR_MISA: begin
				old_val[`XLEN-1 -: 2] = 2'b01;
				old_val[12] = m_ena;
				old_val[8] = 1'b1;
				old_val[5] = f_ena;
			end
			`CSR_MIE:		old_val = mie;
			`CSR_MIP:		old_val = mip;
			`CSR_MTVEC:		old_val = mtvec;
			`CSR_MEPC:		old_val = mepc;
			`CSR_MCAUSE:	old_val = mcause;
			`CSR_FFLAGS:	old_val[4:0] = fflags;
			`CSR_FRM:		old_val[2:0] = frm;
			`CSR_FCSR:		old_val[7:0] = {frm, fflags};
			default:		old_val = '0;
		endcase
		case (csr.op)
			CSR_RW:		new_val = csr.wdata;
			CSR_RS:		new_val = old_val | csr.wdata;
			CSR_RC:		new_val = old_val & ~csr.wdata;
			default:	new_val = old_val;
		endcase
	end

	assign csr.rdata = csr.rena ? old_val : '0;
	assign fpu_rm = frm;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mstatus_fs <= 2'b00;
			m_ena <= 1'b1;
			f_ena <= 1'b1;
			mie <= '0;
			mip <= '0;
			mtvec <= `MTVEC_RESET;
			mepc <= '0;
			mcause <= '0;
			fflags <= '0;
			frm <= '0;
		end else begin
			mip <= irq_lines;
			if (retire)
				fflags <= fflags | csr.fflags;	// Flags accrue on every retire.
			if (csr_write) begin
				case (csr.addr)
					`CSR_MSTATUS: begin
						mstatus_fs <= new_val[14:13];
						mstatus_mpie <= new_val[7];
						mstatus_mie <= new_val[3];
					end
					`CSR_MISA: begin
						m_ena <= new_val[12];
						f_ena <= new_val[5];
					end
					`CSR_MIE:		mie <= new_val & mie_mask;
					`CSR_MTVEC:		mtvec <= new_val;
					`CSR_MEPC:		mepc <= new_val;
					`CSR_MCAUSE:	mcause <= new_val;
					`CSR_FFLAGS:	fflags <= new_val[4:0] | csr.fflags;
					`CSR_FRM:		frm <= new_val[2:0];
					`CSR_FCSR: begin
						frm <= new_val[7:5];
						fflags <= new_val[4:0] | csr.fflags;
					end
					default: ;
				endcase
			end
			if (retire && csr.fpu_dirty)
				mstatus_fs <= 2'b11;
			if (retire && csr.trap_ret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end
			if (csr.trap_taken) begin
				mepc <= csr.pc;
				mcause <= csr.exc_taken ? csr.exc_cause : int_cause;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end
		end
	end

endmodule

// File: design/csr_if.sv
`timescale 1ns/1ps

interface csr_if import rv_wb_pkg::*; ();

	logic		commit;			// Handshake in this cycle.
	csr_op_e	op;
	csr_addr_t	addr;
	word_t		wdata;
	logic		rena;
	logic		wena;
	logic		fpu_dirty;
	fflags_t	fflags;
	logic		exc_pend;
	cause_t		exc_cause;
	logic		trap_ret;
	word_t		pc;

	word_t		rdata;
	logic		exc_taken;
	logic		int_taken;
	logic		trap_taken;
	word_t		trap_addr;
	word_t		trap_raddr;

	modport stage (
		output commit, op, addr, wdata, rena, wena, fpu_dirty, fflags,
		output exc_pend, exc_cause, trap_ret, pc,
		input rdata, exc_taken, int_taken, trap_taken, trap_addr, trap_raddr
	);

	modport csr (
		input commit, op, addr, wdata, rena, wena, fpu_dirty, fflags,
		input exc_pend, exc_cause, trap_ret, pc,
		output rdata, exc_taken, int_taken, trap_taken, trap_addr, trap_raddr
	);

endinterface

// File: design/rv_wb_pkg.sv
`include "rv_wb_cfg.svh"

package rv_wb_pkg;

	typedef logic [`XLEN-1:0]	word_t;

	// Bit 5 selects the floating-point half of the register file.
	typedef logic [5:0]			reg_addr_t;

	typedef logic [11:0]		csr_addr_t;

	typedef logic [4:0]			fflags_t;
	typedef logic [2:0]			frm_t;

	// Bit 31 marks an interrupt and the low bits hold the code.
	typedef word_t				cause_t;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS,
		CSR_RC
	} csr_op_e;

	typedef enum logic [2:0] {
		SEL_ALU,
		SEL_MEM,
		SEL_CSR,
		SEL_FPU
	} wb_src_e;

endpackage

// File: design/rv_wb_cfg.svh
`ifndef RV_WB_CFG_SVH
`define RV_WB_CFG_SVH

`define XLEN		32
`define NUM_REGS	64
`define NUM_IRQ_EXT	16

// Trap vector after reset in direct mode.
`define MTVEC_RESET	32'h0000_0100

`define CSR_FFLAGS	12'h001
`define CSR_FRM		12'h002
`define CSR_FCSR	12'h003
`define CSR_MSTATUS	12'h300
`define CSR_MISA	12'h301
`define CSR_MIE		12'h304
`define CSR_MTVEC	12'h305
`define CSR_MEPC	12'h341
`define CSR_MCAUSE	12'h342
`define CSR_MIP		12'h344

`endif
